// ==== verilog/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry
`define DCACHE_SETS        8
`define DCACHE_WAYS        2
`define DCACHE_BLOCK_WORDS 2

// field widths
`define DCACHE_TAG_W       26
`define DCACHE_SET_W       3

// field positions in the byte address
`define DCACHE_TAG_LSB     6
`define DCACHE_SET_LSB     3
`define DCACHE_WORD_BIT    2

`endif

// ==== verilog/dcache_pkg.sv ====
`include "dcache_consts.svh"

package dcache_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;
   typedef logic [`DCACHE_TAG_W-1:0] tag_t;
   typedef logic [`DCACHE_SET_W-1:0] set_idx_t;
   typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;
   typedef logic [$clog2(`DCACHE_BLOCK_WORDS)-1:0] word_sel_t;

   // one cache line, named by set and way
   typedef struct packed {
      set_idx_t idx;
      way_t     way;
   } line_sel_t;

   typedef struct packed {
      addr_t addr;
      word_t wdata;
      logic  write;
   } cpu_req_t;

   typedef struct packed {
      addr_t addr;
      word_t wdata;
      logic  write;
   } mem_req_t;

   typedef enum logic [2:0] {
      TAG_NONE,
      TAG_TOUCH,
      TAG_DIRTY,
      TAG_FILL,
      TAG_CLEAN
   } tag_op_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WRITEBACK,
      ST_REFILL,
      ST_FLUSH_CHECK,
      ST_FLUSH_WRITE,
      ST_HALTED
   } ctrl_state_t;

endpackage

// ==== verilog/dcache_tag_store.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tag_store (
   input  logic                   CLK,
   input  logic                   nRST,
   input  dcache_pkg::addr_t      lookup_addr,
   input  dcache_pkg::tag_op_t    tag_op,
   input  dcache_pkg::line_sel_t  line_sel,
   output logic                   hit,
   output dcache_pkg::way_t       hit_way,
   output dcache_pkg::way_t       lru_way,
   output dcache_pkg::tag_t       sel_tag,
   output logic                   sel_dirty
);

   import dcache_pkg::*;

   tag_t     tags  [`DCACHE_SETS][`DCACHE_WAYS];
   logic     valid [`DCACHE_SETS][`DCACHE_WAYS];
   logic     dirty [`DCACHE_SETS][`DCACHE_WAYS];
   way_t     lru   [`DCACHE_SETS];
   tag_t     lookup_tag;
   set_idx_t lookup_set;

   assign lookup_tag = lookup_addr[`DCACHE_TAG_LSB +: `DCACHE_TAG_W];
   assign lookup_set = lookup_addr[`DCACHE_SET_LSB +: `DCACHE_SET_W];

   // compare against every valid way of the addressed set
   always_comb
   begin
      hit     = 1'b0;
      hit_way = '0;
      for (int w = 0; w < `DCACHE_WAYS; w++)
      begin
         if (valid[lookup_set][w] && tags[lookup_set][w] == lookup_tag)
         begin
            hit     = 1'b1;
            hit_way = way_t'(w);
         end
      end
   end

   assign lru_way   = lru[lookup_set];
   assign sel_tag   = tags[line_sel.idx][line_sel.way];
   // only a valid line can need a write-back
   assign sel_dirty = valid[line_sel.idx][line_sel.way] & dirty[line_sel.idx][line_sel.way];

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         for (int s = 0; s < `DCACHE_SETS; s++)
         begin
            lru[s] <= '0;
            for (int w = 0; w < `DCACHE_WAYS; w++)
            begin
               valid[s][w] <= 1'b0;
               dirty[s][w] <= 1'b0;
            end
         end
      end
      else
      begin
         case (tag_op)
            TAG_TOUCH:
            begin
               lru[line_sel.idx] <= ~line_sel.way;
            end
            TAG_DIRTY:
            begin
               lru[line_sel.idx]                <= ~line_sel.way;
               dirty[line_sel.idx][line_sel.way] <= 1'b1;
            end
            TAG_FILL:
            begin
               valid[line_sel.idx][line_sel.way] <= 1'b1;
               dirty[line_sel.idx][line_sel.way] <= 1'b0;
            end
            TAG_CLEAN:
            begin
               dirty[line_sel.idx][line_sel.way] <= 1'b0;
            end
            default:
            begin
            end
         endcase
      end
   end

   // tag written from the lookup address on fill
   always_ff @(posedge CLK)
   begin
      if (tag_op == TAG_FILL)
      begin
         tags[line_sel.idx][line_sel.way] <= lookup_tag;
      end
   end

endmodule

// ==== verilog/dcache_data_store.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_data_store (
   input  logic                   CLK,
   input  dcache_pkg::cpu_req_t   cpu_req,
   input  dcache_pkg::way_t       hit_way,
   input  dcache_pkg::line_sel_t  line_sel,
   input  dcache_pkg::word_sel_t  beat,
   input  logic                   store_en,
   input  logic                   fill_en,
   input  dcache_pkg::word_t      mem_rdata,
   input  logic                   beat_done,
   output dcache_pkg::word_t      cpu_rdata,
   output dcache_pkg::word_t      drain_word
);

   import dcache_pkg::*;

   word_t     mem [`DCACHE_SETS][`DCACHE_WAYS][`DCACHE_BLOCK_WORDS];
   set_idx_t  req_set;
   word_sel_t req_word;

   assign req_set  = cpu_req.addr[`DCACHE_SET_LSB +: `DCACHE_SET_W];
   assign req_word = cpu_req.addr[`DCACHE_WORD_BIT];

   // processor side reads the hit way
   assign cpu_rdata  = mem[req_set][hit_way][req_word];
   // memory side reads the selected line, word by beat
   assign drain_word = mem[line_sel.idx][line_sel.way][beat];

   always_ff @(posedge CLK)
   begin
      if (store_en)
      begin
         mem[req_set][hit_way][req_word] <= cpu_req.wdata;
      end
      if (fill_en && beat_done)
      begin
         mem[line_sel.idx][line_sel.way][beat] <= mem_rdata;
      end
   end

endmodule

// ==== verilog/dcache_mem_seq.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_mem_seq (
   input  logic                   CLK,
   input  logic                   nRST,
   input  logic                   xfer_start,
   input  logic                   xfer_write,
   input  dcache_pkg::cpu_req_t   cpu_req,
   input  dcache_pkg::tag_t       sel_tag,
   input  dcache_pkg::line_sel_t  line_sel,
   input  dcache_pkg::word_t      drain_word,
   input  logic                   mem_ready,
   output dcache_pkg::mem_req_t   mem_req,
   output logic                   mem_valid,
   output dcache_pkg::word_sel_t  beat,
   output logic                   beat_done,
   output logic                   xfer_done
);

   import dcache_pkg::*;

   localparam word_sel_t LAST_BEAT = word_sel_t'(`DCACHE_BLOCK_WORDS - 1);

   logic     busy;
   logic     write_q;
   tag_t     tag_q;
   set_idx_t set_q;

   assign mem_valid = busy;
   assign beat_done = busy & mem_ready;
   assign xfer_done = beat_done & (beat == LAST_BEAT);

   assign mem_req.addr  = {tag_q, set_q, beat, 2'b00};
   assign mem_req.wdata = drain_word;
   assign mem_req.write = write_q;

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         busy    <= 1'b0;
         beat    <= '0;
         write_q <= 1'b0;
      end
      else if (xfer_start)
      begin
         // a new start may come in the same cycle the previous block ends
         busy    <= 1'b1;
         beat    <= '0;
         write_q <= xfer_write;
      end
      else if (xfer_done)
      begin
         busy <= 1'b0;
         beat <= '0;
      end
      else if (beat_done)
      begin
         beat <= beat + 1'b1;
      end
   end

   // refill address comes from the held request, not the victim tag
   always_ff @(posedge CLK)
   begin
      if (xfer_start)
      begin
         tag_q <= xfer_write ? sel_tag : cpu_req.addr[`DCACHE_TAG_LSB +: `DCACHE_TAG_W];
         set_q <= line_sel.idx;
      end
   end

endmodule

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ctrl (
   input  logic                   CLK,
   input  logic                   nRST,
   input  logic                   cpu_valid,
   input  logic                   halt,
   input  dcache_pkg::cpu_req_t   cpu_req,
   input  logic                   hit,
   input  logic                   sel_dirty,
   input  dcache_pkg::way_t       hit_way,
   input  dcache_pkg::way_t       lru_way,
   input  logic                   xfer_done,
   output logic                   cpu_ready,
   output logic                   flushed,
   output dcache_pkg::tag_op_t    tag_op,
   output dcache_pkg::line_sel_t  line_sel,
   output logic                   store_en,
   output logic                   fill_en,
   output logic                   xfer_start,
   output logic                   xfer_write
);

   import dcache_pkg::*;

   localparam int LINES = `DCACHE_SETS * `DCACHE_WAYS;
   // one extra bit marks the end of the flush walk
   localparam int CNT_W = $clog2(LINES) + 1;

   ctrl_state_t      state;
   ctrl_state_t      next_state;
   logic [CNT_W-1:0] line_cnt;
   logic [CNT_W-1:0] next_cnt;
   set_idx_t         req_set;

   assign req_set = cpu_req.addr[`DCACHE_SET_LSB +: `DCACHE_SET_W];
   assign flushed = (state == ST_HALTED);

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state    <= ST_IDLE;
         line_cnt <= '0;
      end
      else
      begin
         state    <= next_state;
         line_cnt <= next_cnt;
      end
   end

   always_comb
   begin
      next_state   = state;
      next_cnt     = line_cnt;
      cpu_ready    = 1'b0;
      store_en     = 1'b0;
      fill_en      = 1'b0;
      xfer_start   = 1'b0;
      xfer_write   = 1'b0;
      tag_op       = TAG_NONE;
      // by default point at the victim of the request's set
      line_sel.idx = req_set;
      line_sel.way = lru_way;

      case (state)
         ST_IDLE:
         begin
            if (cpu_valid)
            begin
               if (hit)
               begin
                  cpu_ready    = 1'b1;
                  line_sel.way = hit_way;
                  if (cpu_req.write)
                  begin
                     store_en = 1'b1;
                     tag_op   = TAG_DIRTY;
                  end
                  else
                  begin
                     tag_op = TAG_TOUCH;
                  end
               end
               else
               begin
                  // dirty victim goes out first
                  xfer_start = 1'b1;
                  xfer_write = sel_dirty;
                  next_state = sel_dirty ? ST_WRITEBACK : ST_REFILL;
               end
            end
            else if (halt)
            begin
               next_cnt   = '0;
               next_state = ST_FLUSH_CHECK;
            end
         end

         ST_WRITEBACK:
         begin
            if (xfer_done)
            begin
               xfer_start = 1'b1;
               next_state = ST_REFILL;
            end
         end

         ST_REFILL:
         begin
            fill_en = 1'b1;
            if (xfer_done)
            begin
               // tag and valid land with the last word, request hits next cycle
               tag_op     = TAG_FILL;
               next_state = ST_IDLE;
            end
         end

         ST_FLUSH_CHECK:
         begin
            // way 0 of all sets first, then way 1
            line_sel.idx = line_cnt[`DCACHE_SET_W-1:0];
            line_sel.way = line_cnt[`DCACHE_SET_W];
            if (line_cnt[CNT_W-1])
            begin
               next_state = ST_HALTED;
            end
            else if (sel_dirty)
            begin
               xfer_start = 1'b1;
               xfer_write = 1'b1;
               next_state = ST_FLUSH_WRITE;
            end
            else
            begin
               next_cnt = line_cnt + 1'b1;
            end
         end

         ST_FLUSH_WRITE:
         begin
            line_sel.idx = line_cnt[`DCACHE_SET_W-1:0];
            line_sel.way = line_cnt[`DCACHE_SET_W];
            if (xfer_done)
            begin
               tag_op     = TAG_CLEAN;
               next_cnt   = line_cnt + 1'b1;
               next_state = ST_FLUSH_CHECK;
            end
         end

         ST_HALTED:
         begin
            next_state = ST_HALTED;
         end

         default:
         begin
            next_state = ST_IDLE;
         end
      endcase
   end

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
   input  logic                  CLK,
   input  logic                  nRST,
   input  dcache_pkg::cpu_req_t  cpu_req,
   input  logic                  cpu_valid,
   input  logic                  halt,
   output logic                  cpu_ready,
   output dcache_pkg::word_t     cpu_rdata,
   output logic                  flushed,
   output dcache_pkg::mem_req_t  mem_req,
   output logic                  mem_valid,
   input  logic                  mem_ready,
   input  dcache_pkg::word_t     mem_rdata
);

   import dcache_pkg::*;

   tag_op_t   tag_op;
   line_sel_t line_sel;
   logic      hit;
   way_t      hit_way;
   way_t      lru_way;
   tag_t      sel_tag;
   logic      sel_dirty;
   logic      store_en;
   logic      fill_en;
   logic      xfer_start;
   logic      xfer_write;
   logic      xfer_done;
   logic      beat_done;
   word_sel_t beat;
   word_t     drain_word;

   dcache_ctrl u_ctrl (
      .CLK        (CLK),
      .nRST       (nRST),
      .cpu_valid  (cpu_valid),
      .halt       (halt),
      .cpu_req    (cpu_req),
      .hit        (hit),
      .sel_dirty  (sel_dirty),
      .hit_way    (hit_way),
      .lru_way    (lru_way),
      .xfer_done  (xfer_done),
      .cpu_ready  (cpu_ready),
      .flushed    (flushed),
      .tag_op     (tag_op),
      .line_sel   (line_sel),
      .store_en   (store_en),
      .fill_en    (fill_en),
      .xfer_start (xfer_start),
      .xfer_write (xfer_write)
   );

   dcache_tag_store u_tags (
      .CLK         (CLK),
      .nRST        (nRST),
      .lookup_addr (cpu_req.addr),
      .tag_op      (tag_op),
      .line_sel    (line_sel),
      .hit         (hit),
      .hit_way     (hit_way),
      .lru_way     (lru_way),
      .sel_tag     (sel_tag),
      .sel_dirty   (sel_dirty)
   );

   dcache_data_store u_data (
      .CLK        (CLK),
      .cpu_req    (cpu_req),
      .hit_way    (hit_way),
      .line_sel   (line_sel),
      .beat       (beat),
      .store_en   (store_en),
      .fill_en    (fill_en),
      .mem_rdata  (mem_rdata),
      .beat_done  (beat_done),
      .cpu_rdata  (cpu_rdata),
      .drain_word (drain_word)
   );

   dcache_mem_seq u_seq (
      .CLK        (CLK),
      .nRST       (nRST),
      .xfer_start (xfer_start),
      .xfer_write (xfer_write),
      .cpu_req    (cpu_req),
      .sel_tag    (sel_tag),
      .line_sel   (line_sel),
      .drain_word (drain_word),
      .mem_ready  (mem_ready),
      .mem_req    (mem_req),
      .mem_valid  (mem_valid),
      .beat       (beat),
      .beat_done  (beat_done),
      .xfer_done  (xfer_done)
   );

endmodule

// ==== dv/dcache_mem_model.sv ====
`timescale 1ns/1ps

module dcache_mem_model (
   input  logic                  CLK,
   input  logic                  nRST,
   input  dcache_pkg::mem_req_t  mem_req,
   input  logic                  mem_valid,
   output logic                  mem_ready,
   output dcache_pkg::word_t     mem_rdata,
   output int unsigned           read_count,
   output int unsigned           write_count,
   output int unsigned           stray_count
);

   import dcache_pkg::*;

   // 4 KB window at address zero covers every tag the test uses
   localparam int WORDS = 1024;

   word_t      words [WORDS];
   integer     seed = 32'hdea;
   logic [9:0] index;
   logic       in_window;
   logic       accept;

   assign index     = mem_req.addr[11:2];
   assign in_window = (mem_req.addr[31:12] == '0);
   assign accept    = mem_valid & mem_ready;
   // outside the window a word still reads as its initial pattern
   assign mem_rdata = in_window ? words[index] : ~mem_req.addr;

   initial
   begin
      mem_ready = 1'b0;
      for (int i = 0; i < WORDS; i++)
      begin
         words[i] = ~addr_t'(i * 4);
      end
   end

   // about one cycle in four is a stall
   always @(negedge CLK)
   begin
      mem_ready <= (($random(seed) & 3) != 0);
   end

   always @(posedge CLK)
   begin
      if (accept && mem_req.write && in_window)
      begin
         words[index] <= mem_req.wdata;
      end
   end

   always @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         read_count  <= 0;
         write_count <= 0;
         stray_count <= 0;
      end
      else if (accept)
      begin
         if (mem_req.write)
         begin
            write_count <= write_count + 1;
         end
         else
         begin
            read_count <= read_count + 1;
         end
         if (!in_window)
         begin
            stray_count <= stray_count + 1;
         end
      end
   end

endmodule

// ==== dv/tb_dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module tb_dcache_top;

   import dcache_pkg::*;

   // one processor access and what it must return
   typedef struct packed {
      logic       write;
      addr_t      addr;
      word_t      wdata;
      word_t      exp_rdata;
      logic [7:0] exp_reads;
   } entry_t;

   localparam int N_ENTRIES  = 22;
   localparam int LINES      = `DCACHE_SETS * `DCACHE_WAYS;
   localparam int MAX_CYCLES = (N_ENTRIES + LINES) * 40;
   // same window as the memory model
   localparam int MEM_WORDS  = 1024;

   logic        CLK;
   logic        nRST;
   cpu_req_t    cpu_req;
   logic        cpu_valid;
   logic        halt;
   logic        cpu_ready;
   word_t       cpu_rdata;
   logic        flushed;
   mem_req_t    mem_req;
   logic        mem_valid;
   logic        mem_ready;
   word_t       mem_rdata;
   int unsigned read_count;
   int unsigned write_count;
   int unsigned stray_count;
   int unsigned cycles = 0;
   entry_t      stim [N_ENTRIES];

   dcache_top u_dut (
      .CLK       (CLK),
      .nRST      (nRST),
      .cpu_req   (cpu_req),
      .cpu_valid (cpu_valid),
      .halt      (halt),
      .cpu_ready (cpu_ready),
      .cpu_rdata (cpu_rdata),
      .flushed   (flushed),
      .mem_req   (mem_req),
      .mem_valid (mem_valid),
      .mem_ready (mem_ready),
      .mem_rdata (mem_rdata)
   );

   dcache_mem_model u_mem (
      .CLK         (CLK),
      .nRST        (nRST),
      .mem_req     (mem_req),
      .mem_valid   (mem_valid),
      .mem_ready   (mem_ready),
      .mem_rdata   (mem_rdata),
      .read_count  (read_count),
      .write_count (write_count),
      .stray_count (stray_count)
   );

   initial
   begin
      CLK = 1'b0;
   end

   always #5 CLK = ~CLK;

   always @(posedge CLK)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("cache stopped responding after %0d cycles", cycles);
         abort_run();
      end
   end

   task automatic abort_run();
      $display("TEST FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input int unsigned got,
                              input int unsigned exp);
      if (got !== exp)
      begin
         $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, got);
         abort_run();
      end
   endtask

   // memory starts out holding the inverse of each word's address
   function automatic word_t initial_word(input addr_t a);
      return ~a;
   endfunction

   function automatic entry_t read_op(input addr_t a, input word_t exp, input int reads);
      return '{write: 1'b0, addr: a, wdata: '0, exp_rdata: exp, exp_reads: reads[7:0]};
   endfunction

   function automatic entry_t write_op(input addr_t a, input word_t d, input int reads);
      return '{write: 1'b1, addr: a, wdata: d, exp_rdata: '0, exp_reads: reads[7:0]};
   endfunction

   // last value written to an address anywhere in the table
   function automatic word_t expected_mem(input addr_t a);
      word_t w;
      w = initial_word(a);
      for (int i = 0; i < N_ENTRIES; i++)
      begin
         if (stim[i].write && stim[i].addr == a)
         begin
            w = stim[i].wdata;
         end
      end
      return w;
   endfunction

   task automatic build_stimulus();
      // set 1, cold miss then both words of the block
      stim[0]  = read_op(32'h0000_0048, initial_word(32'h0000_0048), 2);
      stim[1]  = read_op(32'h0000_004c, initial_word(32'h0000_004c), 2);
      stim[2]  = read_op(32'h0000_0048, initial_word(32'h0000_0048), 2);
      // set 2, write-allocate
      stim[3]  = write_op(32'h0000_0094, 32'h1111_2222, 4);
      stim[4]  = read_op(32'h0000_0094, 32'h1111_2222, 4);
      stim[5]  = read_op(32'h0000_0090, initial_word(32'h0000_0090), 4);
      stim[6]  = write_op(32'h0000_0048, 32'h3333_4444, 4);
      stim[7]  = read_op(32'h0000_0048, 32'h3333_4444, 4);
      // set 3, A B A C keeps A and evicts B
      stim[8]  = read_op(32'h0000_0058, initial_word(32'h0000_0058), 6);
      stim[9]  = read_op(32'h0000_0098, initial_word(32'h0000_0098), 8);
      stim[10] = read_op(32'h0000_0058, initial_word(32'h0000_0058), 8);
      stim[11] = read_op(32'h0000_00d8, initial_word(32'h0000_00d8), 10);
      stim[12] = read_op(32'h0000_0058, initial_word(32'h0000_0058), 10);
      stim[13] = read_op(32'h0000_0098, initial_word(32'h0000_0098), 12);
      // set 5, dirty D pushed out by E and F, then read back through memory
      stim[14] = write_op(32'h0000_006c, 32'h5555_6666, 14);
      stim[15] = read_op(32'h0000_00a8, initial_word(32'h0000_00a8), 16);
      stim[16] = read_op(32'h0000_00e8, initial_word(32'h0000_00e8), 18);
      stim[17] = read_op(32'h0000_006c, 32'h5555_6666, 20);
      stim[18] = read_op(32'h0000_0068, initial_word(32'h0000_0068), 20);
      // dirty hits left for the halt flush, including way 1 of set 3
      stim[19] = write_op(32'h0000_00e8, 32'h7777_8888, 20);
      stim[20] = write_op(32'h0000_005c, 32'h9999_aaaa, 20);
      stim[21] = write_op(32'h0000_0098, 32'hbbbb_cccc, 20);
   endtask

   task automatic issue_request(input entry_t e);
      @(negedge CLK);
      cpu_req.addr  = e.addr;
      cpu_req.wdata = e.wdata;
      cpu_req.write = e.write;
      cpu_valid     = 1'b1;
      // the request is taken at the edge where ready is high
      @(posedge CLK);
      while (!cpu_ready)
      begin
         @(posedge CLK);
      end
      if (!e.write)
      begin
         check_word("cpu_rdata", cpu_rdata, e.exp_rdata);
      end
      check_count("read_count", read_count, e.exp_reads);
   endtask

   initial
   begin
      addr_t a;
      cpu_req   = '0;
      cpu_valid = 1'b0;
      halt      = 1'b0;
      nRST      = 1'b0;
      build_stimulus();
      repeat (3) @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;
      @(posedge CLK);
      check_flag("cpu_ready", cpu_ready, 1'b0);
      check_flag("mem_valid", mem_valid, 1'b0);
      check_flag("flushed", flushed, 1'b0);

      for (int i = 0; i < N_ENTRIES; i++)
      begin
         issue_request(stim[i]);
      end

      @(negedge CLK);
      cpu_valid = 1'b0;
      halt      = 1'b1;
      @(posedge CLK);
      while (!flushed)
      begin
         @(posedge CLK);
      end
      // flushed stays up and the memory port goes quiet
      @(posedge CLK);
      check_flag("flushed", flushed, 1'b1);
      check_flag("mem_valid", mem_valid, 1'b0);

      check_count("read_count", read_count, stim[N_ENTRIES-1].exp_reads);
      // one eviction plus five dirty lines at halt, two beats each
      check_count("write_count", write_count, 12);
      check_count("stray_count", stray_count, 0);
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         a = addr_t'(i * 4);
         check_word($sformatf("mem[%h]", a), u_mem.words[i], expected_mem(a));
      end

      $display("TEST PASS");
      $finish;
   end

endmodule

// ==== dcache_top.f ====
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_store.sv
verilog/dcache_mem_seq.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
dv/dcache_mem_model.sv
dv/tb_dcache_top.sv

// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcache_pkg.sv
      - verilog/dcache_tag_store.sv
      - verilog/dcache_data_store.sv
      - verilog/dcache_mem_seq.sv
      - verilog/dcache_ctrl.sv
      - verilog/dcache_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - dv/dcache_mem_model.sv
      - dv/tb_dcache_top.sv
